//--- hw/fxdiv_settings.svh
`ifndef FXDIV_SETTINGS_SVH
`define FXDIV_SETTINGS_SVH

// --------------------------------------------------
// input format, signed Q8.8
// --------------------------------------------------
`define FXDIV_IN_I          8                       // integer bits incl. sign
`define FXDIV_IN_F          8
`define FXDIV_IN_W          (`FXDIV_IN_I + `FXDIV_IN_F)

// --------------------------------------------------
// output format, signed Q12.4
// --------------------------------------------------
`define FXDIV_OUT_I         12
`define FXDIV_OUT_F         4
`define FXDIV_OUT_W         (`FXDIV_OUT_I + `FXDIV_OUT_F)

// divider core sizes
`define FXDIV_MAG_W         (`FXDIV_IN_W - 1)       // magnitude without sign
`define FXDIV_QUO_W         (`FXDIV_MAG_W + `FXDIV_IN_F)   // raw quotient, also iterations
`define FXDIV_ITER_W        5

// flow control
`define FXDIV_FIFO_DEPTH    4                       // upstream starts with this many credits
`define FXDIV_OUT_CREDITS   2                       // granted by downstream after reset

`endif

//--- hw/fxdiv_pkg.sv
`include "fxdiv_settings.svh"

package fxdiv_pkg;

    // request word, both operands signed Q8.8
    typedef struct packed {
        logic signed [`FXDIV_IN_W-1:0] numerator;
        logic signed [`FXDIV_IN_W-1:0] denominator;
    } div_req_t;

    // response word, signed Q12.4 plus divide-by-zero flag
    typedef struct packed {
        logic signed [`FXDIV_OUT_W-1:0] quotient;
        logic                           div_by_zero;
    } div_rsp_t;

    // operand state held by the datapath for one division
    typedef struct packed {
        logic                     q_neg;      // quotient sign
        logic                     n_neg;      // numerator sign, picks div-by-zero value
        logic                     den_zero;
        logic [`FXDIV_MAG_W-1:0]  den_mag;
    } div_op_t;

    // controller states
    typedef enum logic [1:0] {IDLE, LOAD, ITER, WRITE} ctrl_state_t;

endpackage

//--- hw/credit_fifo.sv
`timescale 1ns/10ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     not_full,
    output logic     credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];           // storage, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;           // occupancy

    // --------------------------------------------------
    // storage write
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // --------------------------------------------------
    // pointers, occupancy and credit return
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                // explicit wrap so DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + CNT_W'(push) - CNT_W'(pop);
            credit <= pop;              // one credit back per consumed entry
        end
    end

    assign pop_data  = mem[rd_ptr];    // head visible the cycle after push
    assign not_empty = (count != '0);
    assign not_full  = (count != CNT_W'(DEPTH));

endmodule

//--- hw/iter_counter.sv
`timescale 1ns/10ps
`include "fxdiv_settings.svh"

module iter_counter (
    input  logic clock,
    input  logic reset,
    input  logic load,
    output logic last
);

    logic [`FXDIV_ITER_W-1:0] count;
    logic                     busy;     // division in progress

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (load) begin
            count <= `FXDIV_ITER_W'(`FXDIV_QUO_W - 1);  // 22 down to 0, 23 steps
            busy  <= 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end else begin
            busy  <= 1'b0;              // final bit done
        end
    end

    // high on the step producing the last quotient bit
    assign last = busy && (count == '0);

endmodule

//--- hw/div_ctrl.sv
`timescale 1ns/10ps
`include "fxdiv_settings.svh"

module div_ctrl (
    input  logic clock,
    input  logic reset,
    input  logic req_ready,    // input buffer not empty
    input  logic rsp_room,     // output buffer not full
    input  logic rsp_avail,    // output buffer not empty
    input  logic last_iter,
    input  logic rsp_credit,   // credit back from downstream
    output logic req_pop,
    output logic op_load,
    output logic op_step,
    output logic count_load,
    output logic rsp_push,
    output logic rsp_pop       // also the external rsp_valid
);

    localparam int CRED_W = $clog2(`FXDIV_OUT_CREDITS + 1);

    fxdiv_pkg::ctrl_state_t state;
    fxdiv_pkg::ctrl_state_t state_next;
    logic [CRED_W-1:0]      credit_cnt;   // downstream credits held

    // --------------------------------------------------
    // division sequencing
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            fxdiv_pkg::IDLE:  if (req_ready && rsp_room) state_next = fxdiv_pkg::LOAD;
            fxdiv_pkg::LOAD:  state_next = fxdiv_pkg::ITER;
            fxdiv_pkg::ITER:  if (last_iter) state_next = fxdiv_pkg::WRITE;
            fxdiv_pkg::WRITE: state_next = fxdiv_pkg::IDLE;
            default:          state_next = fxdiv_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= fxdiv_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // pop and capture together, request lands at the LOAD edge
    assign req_pop    = (state == fxdiv_pkg::IDLE) && req_ready && rsp_room;
    assign op_load    = req_pop;
    assign count_load = (state == fxdiv_pkg::LOAD);
    assign op_step    = (state == fxdiv_pkg::ITER);   // 23 cycles
    assign rsp_push   = (state == fxdiv_pkg::WRITE);

    // --------------------------------------------------
    // downstream credits
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credit_cnt <= CRED_W'(`FXDIV_OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CRED_W'(rsp_credit) - CRED_W'(rsp_pop);
        end
    end

    // send only with a credit in hand
    assign rsp_pop = (credit_cnt != '0) && rsp_avail;

endmodule

//--- hw/div_datapath.sv
`timescale 1ns/10ps
`include "fxdiv_settings.svh"

module div_datapath (
    input  logic                 clock,
    input  logic                 reset,
    input  fxdiv_pkg::div_req_t  req,
    input  logic                 op_load,
    input  logic                 op_step,
    output fxdiv_pkg::div_rsp_t  rsp
);

    localparam int IN_W  = `FXDIV_IN_W;
    localparam int MAG_W = `FXDIV_MAG_W;
    localparam int QUO_W = `FXDIV_QUO_W;
    localparam int OUT_W = `FXDIV_OUT_W;
    localparam int DROP  = `FXDIV_IN_F - `FXDIV_OUT_F;   // 4 fraction bits dropped
    localparam int NAR_W = QUO_W - DROP;                // Q15.4 magnitude
    localparam logic [NAR_W-1:0] POS_LIM = NAR_W'((1 << (OUT_W - 1)) - 1);
    localparam logic [NAR_W-1:0] NEG_LIM = NAR_W'(1 << (OUT_W - 1));

    fxdiv_pkg::div_op_t op;
    logic [MAG_W-1:0]   acc;        // partial remainder
    logic [QUO_W-1:0]   quo;        // dividend in, quotient bits shift in from the right
    logic [MAG_W:0]     trial;
    logic [NAR_W-1:0]   trunc;
    logic [NAR_W-1:0]   sat;
    logic [OUT_W-1:0]   value;

    // magnitude of a signed input word
    function automatic logic [MAG_W-1:0] magnitude(input logic [IN_W-1:0] v);
        logic [IN_W-1:0] neg;
        neg = -v;
        if (!v[IN_W-1]) begin
            return v[MAG_W-1:0];
        end else if (neg[IN_W-1]) begin
            return '1;              // -128.0 has no 15 bit magnitude, clamp
        end else begin
            return neg[MAG_W-1:0];
        end
    endfunction

    // --------------------------------------------------
    // operand capture
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            op <= '0;
        end else if (op_load) begin
            op.q_neg    <= req.numerator[IN_W-1] ^ req.denominator[IN_W-1];
            op.n_neg    <= req.numerator[IN_W-1];
            op.den_zero <= (req.denominator == '0);
            op.den_mag  <= magnitude(req.denominator);
        end
    end

    // --------------------------------------------------
    // restoring shift-subtract, one bit per step
    // --------------------------------------------------
    assign trial = {acc, quo[QUO_W-1]};   // remainder shifted, next dividend bit in

    always_ff @(posedge clock) begin
        if (op_load) begin
            acc <= '0;
            quo <= {magnitude(req.numerator), {`FXDIV_IN_F{1'b0}}};   // Q15.8 scaling
        end else if (op_step) begin
            if (trial >= {1'b0, op.den_mag}) begin
                acc <= MAG_W'(trial - {1'b0, op.den_mag});   // fits, remainder < divisor
                quo <= {quo[QUO_W-2:0], 1'b1};
            end else begin
                acc <= trial[MAG_W-1:0];
                quo <= {quo[QUO_W-2:0], 1'b0};
            end
        end
    end

    // --------------------------------------------------
    // narrowing, sign and saturation
    // --------------------------------------------------
    always_comb begin
        trunc = quo[QUO_W-1:DROP];      // truncate magnitude, so toward zero
        if (op.q_neg) begin
            sat   = (trunc > NEG_LIM) ? NEG_LIM : trunc;
            value = -sat[OUT_W-1:0];    // 0x8000 stays most negative
        end else begin
            sat   = (trunc > POS_LIM) ? POS_LIM : trunc;
            value = sat[OUT_W-1:0];
        end

        rsp.div_by_zero = op.den_zero;
        if (op.den_zero) begin
            // sign of numerator picks the rail
            rsp.quotient = op.n_neg ? NEG_LIM[OUT_W-1:0] : POS_LIM[OUT_W-1:0];
        end else begin
            rsp.quotient = value;
        end
    end

endmodule

//--- hw/fxdiv_top.sv
`timescale 1ns/10ps
`include "fxdiv_settings.svh"

module fxdiv_top (
    input  logic                clock,
    input  logic                reset,
    // upstream, credit based
    input  logic                req_valid,
    input  fxdiv_pkg::div_req_t req,
    output logic                req_credit,
    // downstream, credit based
    output logic                rsp_valid,
    output fxdiv_pkg::div_rsp_t rsp,
    input  logic                rsp_credit
);

    fxdiv_pkg::div_req_t req_head;     // oldest buffered request
    fxdiv_pkg::div_rsp_t rsp_word;     // datapath result
    logic req_ready;
    logic rsp_room;
    logic rsp_avail;
    logic req_pop;
    logic op_load;
    logic op_step;
    logic count_load;
    logic last_iter;
    logic rsp_push;
    logic rsp_pop;

    // --------------------------------------------------
    // request buffer, credit per pop goes upstream
    // --------------------------------------------------
    credit_fifo #(
        .payload_t (fxdiv_pkg::div_req_t),
        .DEPTH     (`FXDIV_FIFO_DEPTH)
    ) u_req_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (req_valid),
        .push_data (req),
        .pop       (req_pop),
        .pop_data  (req_head),
        .not_empty (req_ready),
        .not_full  (),
        .credit    (req_credit)
    );

    div_ctrl u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .req_ready  (req_ready),
        .rsp_room   (rsp_room),
        .rsp_avail  (rsp_avail),
        .last_iter  (last_iter),
        .rsp_credit (rsp_credit),
        .req_pop    (req_pop),
        .op_load    (op_load),
        .op_step    (op_step),
        .count_load (count_load),
        .rsp_push   (rsp_push),
        .rsp_pop    (rsp_pop)
    );

    iter_counter u_iter (
        .clock (clock),
        .reset (reset),
        .load  (count_load),
        .last  (last_iter)
    );

    div_datapath u_path (
        .clock   (clock),
        .reset   (reset),
        .req     (req_head),
        .op_load (op_load),
        .op_step (op_step),
        .rsp     (rsp_word)
    );

    // --------------------------------------------------
    // response buffer, drained by downstream credits
    // --------------------------------------------------
    credit_fifo #(
        .payload_t (fxdiv_pkg::div_rsp_t),
        .DEPTH     (`FXDIV_FIFO_DEPTH)
    ) u_rsp_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (rsp_push),
        .push_data (rsp_word),
        .pop       (rsp_pop),
        .pop_data  (rsp),
        .not_empty (rsp_avail),
        .not_full  (rsp_room),
        .credit    ()
    );

    assign rsp_valid = rsp_pop;   // each send spends one credit

endmodule

//--- verif/fxdiv_checker.sv
`timescale 1ns/10ps
`include "fxdiv_settings.svh"

module fxdiv_checker (
    input logic                   clock,
    input logic                   reset,
    input logic                   req_valid,
    input logic                   req_credit,
    input logic                   req_pop,
    input logic                   rsp_valid,
    input logic                   rsp_credit,
    input logic                   rsp_push,
    input fxdiv_pkg::ctrl_state_t state
);

    int failures = 0;       // failed assertions
    int held;               // downstream credits seen at the ports
    int accepted;           // requests pushed
    int popped;             // input buffer pops
    int given;              // req_credit pulses

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            held     <= `FXDIV_OUT_CREDITS;
            accepted <= 0;
            popped   <= 0;
            given    <= 0;
        end else begin
            held     <= held + int'(rsp_credit) - int'(rsp_valid);
            accepted <= accepted + int'(req_valid);
            popped   <= popped + int'(req_pop);
            given    <= given + int'(req_credit);
        end
    end

    // --------------------------------------------------
    // credit rules
    // --------------------------------------------------
    a_send_credit: assert property (@(posedge clock) disable iff (reset)
        rsp_valid |-> held != 0)
        else begin $error("rsp_valid with no downstream credit"); failures++; end

    a_pop_ready: assert property (@(posedge clock) disable iff (reset)
        req_pop |-> popped < accepted)
        else begin $error("req_pop with no request in the input buffer"); failures++; end

    a_credit_bound: assert property (@(posedge clock) disable iff (reset)
        given <= accepted)
        else begin $error("more req_credit pulses than requests"); failures++; end

    // control outputs
    a_reset_quiet: assert property (@(posedge clock)
        $fell(reset) |-> !rsp_valid && state == fxdiv_pkg::IDLE)
        else begin $error("rsp_valid or busy controller right after reset"); failures++; end

    a_push_latency: assert property (@(posedge clock) disable iff (reset)
        rsp_push |-> $past(req_pop, 25))
        else begin $error("rsp_push not 25 cycles after req_pop"); failures++; end

endmodule

//--- verif/fxdiv_tb.sv
`timescale 1ns/10ps
`include "fxdiv_settings.svh"

module fxdiv_tb;

    localparam logic [31:0] SEED    = 32'hb15c281e;
    localparam int          TIMEOUT = 2000;             // cycles per response
    localparam int          POS_MAX = (1 << (`FXDIV_OUT_W - 1)) - 1;

    logic                clock;
    logic                reset;
    logic                req_valid;
    fxdiv_pkg::div_req_t req;
    logic                req_credit;
    logic                rsp_valid;
    fxdiv_pkg::div_rsp_t rsp;
    logic                rsp_credit;

    fxdiv_pkg::div_rsp_t expected [$];                 // model results in send order
    int   seed         = int'(SEED);                   // operand stream
    int   delay_seed   = int'(SEED);                   // credit return delays
    int   sent         = 0;
    int   received     = 0;
    int   returned     = 0;                            // credits given back downstream
    int   credits_back = 0;                            // req_credit pulses seen
    int   errors       = 0;
    int   timeouts     = 0;
    int   base;
    logic hold         = 1'b0;                         // withhold downstream credits

    fxdiv_top u_dut (
        .clock      (clock),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    bind fxdiv_top fxdiv_checker u_checker (
        .clock      (clock),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .req_pop    (req_pop),
        .rsp_valid  (rsp_valid),
        .rsp_credit (rsp_credit),
        .rsp_push   (rsp_push),
        .state      (u_ctrl.state)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #2 clock = ~clock;                     // 4 ns period
    end

    // --------------------------------------------------
    // reference model truncating toward zero then saturating
    // --------------------------------------------------
    function automatic fxdiv_pkg::div_rsp_t model(input logic signed [`FXDIV_IN_W-1:0] num,
                                                  input logic signed [`FXDIV_IN_W-1:0] den);
        fxdiv_pkg::div_rsp_t r;
        int n_mag;
        int d_mag;
        int q;
        n_mag = int'(num);
        d_mag = int'(den);
        if (n_mag < 0) n_mag = -n_mag;
        if (d_mag < 0) d_mag = -d_mag;
        r.div_by_zero = (d_mag == 0);
        if (d_mag == 0) begin
            q = (num < 0) ? -(POS_MAX + 1) : POS_MAX;  // rail picked by numerator sign
        end else begin
            q = (n_mag << `FXDIV_OUT_F) / d_mag;        // Q8.8 over Q8.8 into Q12.4
            if ((num < 0) != (den < 0)) begin
                q = (q > POS_MAX + 1) ? -(POS_MAX + 1) : -q;
            end else if (q > POS_MAX) begin
                q = POS_MAX;
            end
        end
        r.quotient = `FXDIV_OUT_W'(q);
        return r;
    endfunction

    function automatic logic signed [`FXDIV_IN_W-1:0] rand_operand();
        logic signed [`FXDIV_IN_W-1:0] v;
        v = `FXDIV_IN_W'($random(seed));
        if (v == 16'sh8000) v = 16'sh8001;             // -128.0 has no 15 bit magnitude
        return v;
    endfunction

    // upstream credit pulses counted like a flop
    always @(posedge clock) begin
        if (!reset && req_credit) credits_back <= credits_back + 1;
    end

    // in-order response check
    always @(posedge clock) begin : monitor
        fxdiv_pkg::div_rsp_t exp;
        if (!reset && rsp_valid) begin
            received++;
            assert (expected.size() != 0) else begin
                errors++;
                $display("response arrived with no request outstanding");
            end
            if (expected.size() != 0) begin
                exp = expected.pop_front();
                assert (rsp.quotient == exp.quotient) else begin
                    errors++;
                    $display("ERROR: rsp.quotient = %h, expected %h", rsp.quotient, exp.quotient);
                end
                assert (rsp.div_by_zero == exp.div_by_zero) else begin
                    errors++;
                    $display("ERROR: rsp.div_by_zero = %h, expected %h",
                             rsp.div_by_zero, exp.div_by_zero);
                end
            end
        end
    end

    // downstream returns one credit per response after a random delay
    initial begin : credit_return
        rsp_credit = 1'b0;
        forever begin
            @(negedge clock);
            rsp_credit = 1'b0;
            if (!hold && received > returned && ($random(delay_seed) & 3) == 0) begin
                rsp_credit = 1'b1;
                returned++;
            end
        end
    end

    task automatic send_req(input logic signed [`FXDIV_IN_W-1:0] num,
                            input logic signed [`FXDIV_IN_W-1:0] den);
        int waited;
        waited = 0;
        @(negedge clock);
        req_valid = 1'b0;
        while (`FXDIV_FIFO_DEPTH + credits_back - sent <= 0 && waited < TIMEOUT) begin
            @(negedge clock);                          // hold off without a credit
            waited++;
        end
        if (waited >= TIMEOUT) begin
            timeouts++;
            $display("timeout: no request credit came back");
        end else begin
            req.numerator   = num;
            req.denominator = den;
            req_valid       = 1'b1;
            sent++;
            expected.push_back(model(num, den));
        end
    endtask

    task automatic wait_responses(input int count);
        int waited;
        int seen;
        waited = 0;
        seen   = received;
        @(negedge clock);
        req_valid = 1'b0;
        while (received < count && waited < TIMEOUT) begin
            @(negedge clock);
            if (received != seen) begin
                seen   = received;
                waited = 0;                            // restart per response
            end else begin
                waited++;
            end
        end
        if (received < count) begin
            timeouts++;
            $display("timeout: only %0d of %0d responses arrived", received, count);
        end
    endtask

    task automatic wait_credits_home();
        int waited;
        waited = 0;
        while (returned < received && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (returned < received) begin
            timeouts++;
            $display("timeout: downstream credits were not all returned");
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : main
        logic signed [`FXDIV_IN_W-1:0] a;
        logic signed [`FXDIV_IN_W-1:0] b;
        int total;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        // small operands over all four sign combinations
        for (int s = 0; s < 4; s++) begin
            send_req(s[0] ? -16'sh0300 : 16'sh0300, s[1] ? -16'sh0200 : 16'sh0200);
            send_req(s[0] ? -16'sh0100 : 16'sh0100, s[1] ? -16'sh0300 : 16'sh0300);
            send_req(s[0] ? -16'sh0a40 : 16'sh0a40, s[1] ? -16'sh0180 : 16'sh0180);
        end
        for (int i = 0; i < 16; i++) begin
            a = rand_operand();
            b = rand_operand();
            send_req(a, b);
        end

        // saturation then zero denominators
        send_req(16'sh7fff, 16'sh0001);
        send_req(-16'sh7fff, 16'sh0001);
        send_req(16'sh7fff, -16'sh0001);
        send_req(-16'sh7fff, -16'sh0001);
        send_req(16'sh4000, 16'sh0008);
        send_req(16'sh0500, 16'sh0000);
        send_req(16'sh0000, 16'sh0000);
        send_req(-16'sh0500, 16'sh0000);
        wait_responses(sent);

        // burst of twelve at credit rate
        for (int i = 0; i < 12; i++) begin
            a = rand_operand();
            b = rand_operand();
            send_req(a, b);
        end
        wait_responses(sent);
        assert (credits_back == sent) else begin
            errors++;
            $display("ERROR: req_credit pulses = %h, expected %h", credits_back, sent);
        end

        // downstream credits withheld
        wait_credits_home();
        @(posedge clock);
        hold = 1'b1;
        @(negedge clock);
        base = received;
        for (int i = 0; i < 6; i++) begin
            a = rand_operand();
            b = rand_operand();
            send_req(a, b);
        end
        @(negedge clock);
        req_valid = 1'b0;
        repeat (200) @(negedge clock);
        assert (received - base == `FXDIV_OUT_CREDITS) else begin
            errors++;
            $display("ERROR: rsp_valid count while held = %h, expected %h",
                     received - base, `FXDIV_OUT_CREDITS);
        end
        @(posedge clock);
        hold = 1'b0;
        wait_responses(sent);

        repeat (5) @(negedge clock);
        total = errors + timeouts + u_dut.u_checker.failures;
        $display("errors %0d, timeouts %0d, assertion failures %0d",
                 errors, timeouts, u_dut.u_checker.failures);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+hw
hw/fxdiv_pkg.sv
hw/credit_fifo.sv
hw/iter_counter.sv
hw/div_ctrl.sv
hw/div_datapath.sv
hw/fxdiv_top.sv
verif/fxdiv_checker.sv
verif/fxdiv_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/10ps -Wall
TOP        ?= fxdiv_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
